/* Makefile */
# Verilator build and run for the drive selector testbench

VERILATOR ?= verilator
TOP       ?= tb_drive_selector
FLIST     ?= sources.f
OBJ_DIR   ?= obj_dir
BIN_NAME  ?= V$(TOP)
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/$(BIN_NAME)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST) testbench/selector_tests.txt
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(BIN_NAME)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^Test passed$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/drive_array.sv */
// one drive family: per-slot sector engines, command decode and result arbitration
module drive_array #(
   parameter int                 DRIVES = 2,
   parameter drive_pkg::family_e FAMILY = drive_pkg::FAM_DD
) (
   input  logic              clk_sys,
   input  logic              rst_n_i,
   input  logic              family_ready_i,
   input  logic [DRIVES-1:0] slot_active_i,
   input  logic              defer_i,         // other family has the port
   input  logic [7:0]        par_data_i,
   input  logic              par_stb_i,
   input  logic [DRIVES-1:0] sd_ack_i,
   input  logic [7:0]        sd_buff_dout_i,
   input  logic              sd_buff_wr_i,
   output logic [DRIVES-1:0] sd_rd_o,
   output drive_pkg::lba_t   sd_lba_o [DRIVES],
   output logic [DRIVES-1:0] busy_o,
   output logic              iec_data_o,
   output logic [7:0]        par_data_o,
   output logic              par_stb_o
);
   import drive_pkg::*;

   slot_t             cmd_slot;
   logic [DRIVES-1:0] cmd;
   logic [DRIVES-1:0] hold;
   logic [DRIVES-1:0] pending;
   logic [DRIVES-1:0] grant;
   logic [7:0]        result [DRIVES];
   logic [7:0]        grant_data;

   assign cmd_slot = par_data_i[7:6];

   for (genvar i = 0; i < DRIVES; i++) begin : g_eng
      assign cmd[i]  = par_stb_i && (cmd_slot == slot_t'(i));
      assign hold[i] = !(family_ready_i && slot_active_i[i]);  // rom missing or other family

      sector_engine u_eng (
         .clk_sys        (clk_sys),
         .rst_n_i        (rst_n_i),
         .hold_i         (hold[i]),
         .cmd_i          (cmd[i]),
         .sector_i       (par_data_i[5:0]),
         .sd_ack_i       (sd_ack_i[i]),
         .sd_buff_dout_i (sd_buff_dout_i),
         .sd_buff_wr_i   (sd_buff_wr_i),
         .grant_i        (grant[i]),
         .busy_o         (busy_o[i]),
         .pending_o      (pending[i]),
         .result_o       (result[i]),
         .sd_rd_o        (sd_rd_o[i]),
         .sd_lba_o       (sd_lba_o[i])
      );
   end

   // lowest pending slot wins
   always_comb begin
      grant      = '0;
      grant_data = 8'h00;
      for (int i = DRIVES - 1; i >= 0; i--) begin
         if (pending[i]) begin
            grant      = '0;
            grant[i]   = 1'b1;
            grant_data = result[i];
         end
      end
      if (defer_i) begin
         grant = '0;
      end
   end

   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         par_stb_o <= 1'b0;
      end else begin
         par_stb_o <= |grant;
      end
   end

   always_ff @(posedge clk_sys) begin
      if (|grant) begin
         par_data_o <= grant_data;
      end
   end

   assign iec_data_o = ~|busy_o;  // busy engines pull data low

   // shared SD data lines carry one slot at a time
   a_one_ack : assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      $onehot0(sd_ack_i))
      else $error("drive_array: family %0d saw acks for several slots", FAMILY);

endmodule

/* logic/drive_pkg.sv */
// shared types and constants for the drive selector, imported by the RTL and the SD model
package drive_pkg;

   // ------------------------------
   // drive families
   // ------------------------------
   typedef enum logic {
      FAM_DD = 1'b0,  // d64/d71/g64 drives
      FAM_HD = 1'b1   // d81 drives
   } family_e;

   typedef logic [31:0] lba_t;
   typedef logic [5:0]  blk_cnt_t;  // blocks beyond the first
   typedef logic [5:0]  sector_t;
   typedef logic [1:0]  slot_t;

   // flag order matches the host image type word
   typedef struct packed {
      logic hd;
      logic mfm;
      logic ds;
   } img_type_t;

   // ------------------------------
   // rom file extensions
   // ------------------------------
   localparam logic [15:0] EXT_41 = "41";
   localparam logic [15:0] EXT_70 = "70";
   localparam logic [15:0] EXT_71 = "71";
   localparam logic [15:0] EXT_81 = "81";  // only hd extension

   localparam int BYTES_PER_BLOCK = 512;

endpackage

/* logic/drive_selector.sv */
// drive selector top: routes each slot to the DD or HD family and merges their SD and bus traffic
module drive_selector #(
   parameter int DRIVES    = 2,
   parameter int ROM_BYTES = 16
) (
   input  logic                 clk_sys,
   input  logic                 rst_n_i,
   input  logic [DRIVES-1:0]    img_mounted_i,
   input  logic [31:0]          img_size_i,
   input  drive_pkg::img_type_t img_type_i,
   input  logic [31:0]          rom_file_ext_i,
   input  logic                 rom_wr_i,
   input  logic [7:0]           par_data_i,
   input  logic                 par_stb_i,
   input  logic [DRIVES-1:0]    sd_ack_i,
   input  logic [15:0]          sd_buff_addr_i,  // bytes are counted by strobe
   input  logic [7:0]           sd_buff_dout_i,
   input  logic                 sd_buff_wr_i,
   output logic [DRIVES-1:0]    led_o,
   output logic                 iec_data_o,
   output logic [7:0]           par_data_o,
   output logic                 par_stb_o,
   output logic [DRIVES-1:0]    sd_rd_o,
   output drive_pkg::lba_t      sd_lba_o [DRIVES],
   output drive_pkg::blk_cnt_t  sd_blk_cnt_o [DRIVES]
);
   import drive_pkg::*;

   logic [DRIVES-1:0] img_hd;
   logic              dd_ready, hd_ready;

   logic [DRIVES-1:0] dd_sd_rd, hd_sd_rd;
   lba_t              dd_sd_lba [DRIVES];
   lba_t              hd_sd_lba [DRIVES];
   logic [DRIVES-1:0] dd_busy, hd_busy;
   logic              dd_iec, hd_iec;
   logic [7:0]        dd_par, hd_par;
   logic              dd_stb, hd_stb;

   image_type_latch #(.DRIVES(DRIVES)) u_type (
      .clk_sys       (clk_sys),
      .rst_n_i       (rst_n_i),
      .img_mounted_i (img_mounted_i),
      .img_size_i    (img_size_i),
      .img_type_i    (img_type_i),
      .img_hd_o      (img_hd),
      .img_mfm_o     (),  // no gcr/mfm decoding here
      .img_ds_o      ()
   );

   rom_loader #(.ROM_BYTES(ROM_BYTES)) u_rom (
      .clk_sys        (clk_sys),
      .rst_n_i        (rst_n_i),
      .rom_file_ext_i (rom_file_ext_i),
      .rom_wr_i       (rom_wr_i),
      .dd_ready_o     (dd_ready),
      .hd_ready_o     (hd_ready)
   );

   // ------------------------------
   // family arrays
   // ------------------------------
   drive_array #(.DRIVES(DRIVES), .FAMILY(FAM_DD)) u_dd (
      .clk_sys        (clk_sys),
      .rst_n_i        (rst_n_i),
      .family_ready_i (dd_ready),
      .slot_active_i  (~img_hd),
      .defer_i        (1'b0),
      .par_data_i     (par_data_i),
      .par_stb_i      (par_stb_i),
      .sd_ack_i       (sd_ack_i),
      .sd_buff_dout_i (sd_buff_dout_i),
      .sd_buff_wr_i   (sd_buff_wr_i),
      .sd_rd_o        (dd_sd_rd),
      .sd_lba_o       (dd_sd_lba),
      .busy_o         (dd_busy),
      .iec_data_o     (dd_iec),
      .par_data_o     (dd_par),
      .par_stb_o      (dd_stb)
   );

   drive_array #(.DRIVES(DRIVES), .FAMILY(FAM_HD)) u_hd (
      .clk_sys        (clk_sys),
      .rst_n_i        (rst_n_i),
      .family_ready_i (hd_ready),
      .slot_active_i  (img_hd),
      .defer_i        (|dd_busy),  // dd results go first
      .par_data_i     (par_data_i),
      .par_stb_i      (par_stb_i),
      .sd_ack_i       (sd_ack_i),
      .sd_buff_dout_i (sd_buff_dout_i),
      .sd_buff_wr_i   (sd_buff_wr_i),
      .sd_rd_o        (hd_sd_rd),
      .sd_lba_o       (hd_sd_lba),
      .busy_o         (hd_busy),
      .iec_data_o     (hd_iec),
      .par_data_o     (hd_par),
      .par_stb_o      (hd_stb)
   );

   // per-slot SD routing
   always_comb begin
      for (int i = 0; i < DRIVES; i++) begin
         if (img_hd[i]) begin
            sd_rd_o[i]      = hd_sd_rd[i];
            sd_lba_o[i]     = hd_sd_lba[i] << 1;  // 1k sectors on 512-byte blocks
            sd_blk_cnt_o[i] = blk_cnt_t'(1);
         end else begin
            sd_rd_o[i]      = dd_sd_rd[i];
            sd_lba_o[i]     = dd_sd_lba[i];
            sd_blk_cnt_o[i] = blk_cnt_t'(0);
         end
      end
   end

   assign led_o      = dd_busy | hd_busy;
   assign iec_data_o = dd_iec & hd_iec;  // wired-AND
   assign par_stb_o  = dd_stb | hd_stb;
   assign par_data_o = dd_stb ? dd_par : hd_par;

   // cross-family arbitration keeps the response port single-driven
   a_one_stb : assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      !(dd_stb && hd_stb))
      else $error("drive_selector: both families strobed par_stb_o");

endmodule

/* logic/image_type_latch.sv */
// per-slot image type flags, captured on every mount with a nonzero image size
module image_type_latch #(
   parameter int DRIVES = 2
) (
   input  logic                 clk_sys,
   input  logic                 rst_n_i,
   input  logic [DRIVES-1:0]    img_mounted_i,
   input  logic [31:0]          img_size_i,
   input  drive_pkg::img_type_t img_type_i,
   output logic [DRIVES-1:0]    img_hd_o,
   output logic [DRIVES-1:0]    img_mfm_o,
   output logic [DRIVES-1:0]    img_ds_o
);
   import drive_pkg::*;

   img_type_t type_q [DRIVES];

   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < DRIVES; i++) begin
            type_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < DRIVES; i++) begin
            if (img_mounted_i[i] && (img_size_i != '0)) begin  // size 0 is an eject
               type_q[i] <= img_type_i;
            end
         end
      end
   end

   always_comb begin
      for (int i = 0; i < DRIVES; i++) begin
         img_hd_o[i]  = type_q[i].hd;
         img_mfm_o[i] = type_q[i].mfm;
         img_ds_o[i]  = type_q[i].ds;
      end
   end

   // the host mounts one slot at a time
   a_one_mount : assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      $onehot0(img_mounted_i))
      else $error("image_type_latch: several slots mounted in one cycle");

endmodule

/* logic/rom_loader.sv */
// counts drive ROM download bytes per family and releases a family once its ROM is complete
module rom_loader #(
   parameter int ROM_BYTES = 16
) (
   input  logic        clk_sys,
   input  logic        rst_n_i,
   input  logic [31:0] rom_file_ext_i,
   input  logic        rom_wr_i,
   output logic        dd_ready_o,
   output logic        hd_ready_o
);
   import drive_pkg::*;

   localparam int CW = $clog2(ROM_BYTES + 1);

   logic [15:0]   ext;
   logic          ext_known;
   family_e       target;
   logic [CW-1:0] cnt_q [2];

   assign ext       = rom_file_ext_i[15:0];  // last two characters
   assign ext_known = (ext == EXT_41) || (ext == EXT_70) || (ext == EXT_71) ||
                      (ext == EXT_81);
   assign target    = (ext == EXT_81) ? FAM_HD : FAM_DD;

   // one saturating byte counter per family
   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q[0] <= '0;
         cnt_q[1] <= '0;
      end else begin
         for (int f = 0; f < 2; f++) begin
            if (rom_wr_i && ext_known && (target == family_e'(f)) &&
                (cnt_q[f] != CW'(ROM_BYTES))) begin
               cnt_q[f] <= cnt_q[f] + 1'b1;
            end
         end
      end
   end

   assign dd_ready_o = (cnt_q[FAM_DD] == CW'(ROM_BYTES));
   assign hd_ready_o = (cnt_q[FAM_HD] == CW'(ROM_BYTES));

endmodule

/* logic/sector_engine.sv */
// sector read engine for one drive slot; fetches a sector over SD and holds its checksum
module sector_engine (
   input  logic               clk_sys,
   input  logic               rst_n_i,
   input  logic               hold_i,
   input  logic               cmd_i,
   input  drive_pkg::sector_t sector_i,
   input  logic               sd_ack_i,
   input  logic [7:0]         sd_buff_dout_i,
   input  logic               sd_buff_wr_i,
   input  logic               grant_i,
   output logic               busy_o,
   output logic               pending_o,
   output logic [7:0]         result_o,
   output logic               sd_rd_o,
   output drive_pkg::lba_t    sd_lba_o
);
   import drive_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,   // sd_rd up, waiting for ack
      ST_XFER,  // bytes arriving
      ST_PEND   // result waiting for the port
   } state_e;

   state_e     state_q;
   logic       sd_rd_q;
   lba_t       lba_q;
   logic [7:0] csum_q;
   logic       accept;
   logic       take_byte;

   assign accept    = (state_q == ST_IDLE) && cmd_i;
   assign take_byte = ((state_q == ST_REQ) || (state_q == ST_XFER)) &&
                      sd_ack_i && sd_buff_wr_i;

   // ------------------------------
   // control
   // ------------------------------
   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
         sd_rd_q <= 1'b0;
      end else if (hold_i) begin
         state_q <= ST_IDLE;
         sd_rd_q <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (cmd_i) begin
                  state_q <= ST_REQ;
               end
            end
            ST_REQ: begin
               if (sd_ack_i) begin
                  sd_rd_q <= 1'b0;  // drop on first ack
                  state_q <= ST_XFER;
               end else begin
                  sd_rd_q <= 1'b1;
               end
            end
            ST_XFER: begin
               if (!sd_ack_i) begin
                  state_q <= ST_PEND;
               end
            end
            ST_PEND: begin
               if (grant_i) begin
                  state_q <= ST_IDLE;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // ------------------------------
   // address and checksum
   // ------------------------------
   always_ff @(posedge clk_sys) begin
      if (accept) begin
         lba_q  <= lba_t'(sector_i);
         csum_q <= 8'h00;
      end else if (take_byte) begin
         csum_q <= csum_q ^ sd_buff_dout_i;
      end
   end

   assign busy_o    = (state_q != ST_IDLE);
   assign pending_o = (state_q == ST_PEND);
   assign result_o  = csum_q;
   assign sd_rd_o   = sd_rd_q;
   assign sd_lba_o  = lba_q;

   // a finished transfer must not leave a read request behind
   a_no_rd_pending : assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      (state_q == ST_PEND) |-> !sd_rd_o)
      else $error("sector_engine: sd_rd high while result pending");

endmodule

/* sources.f */
logic/drive_pkg.sv
logic/image_type_latch.sv
logic/rom_loader.sv
logic/sector_engine.sv
logic/drive_array.sv
logic/drive_selector.sv
testbench/sd_card_model.sv
testbench/tb_drive_selector.sv

/* testbench/sd_card_model.sv */
// behavioral SD block server; serves one slot read at a time with bytes of (lba + address)
module sd_card_model #(
   parameter int DRIVES = 4
) (
   input  logic                clk_sys,
   input  logic                rst_n_i,
   input  logic [DRIVES-1:0]   sd_rd_i,
   input  drive_pkg::lba_t     sd_lba_i [DRIVES],
   input  drive_pkg::blk_cnt_t sd_blk_cnt_i [DRIVES],
   output logic [DRIVES-1:0]   sd_ack_o,
   output logic [15:0]         sd_buff_addr_o,
   output logic [7:0]          sd_buff_dout_o,
   output logic                sd_buff_wr_o
);
   timeunit 1ns;
   timeprecision 100ps;
   import drive_pkg::*;

   initial begin
      sd_ack_o       = '0;
      sd_buff_addr_o = '0;
      sd_buff_dout_o = '0;
      sd_buff_wr_o   = 1'b0;
   end

   always begin : serve
      int   sel;
      int   len;
      lba_t lba;
      @(negedge clk_sys);
      sel = -1;
      for (int i = DRIVES - 1; i >= 0; i--) begin  // lowest slot first
         if (rst_n_i && sd_rd_i[i]) begin
            sel = i;
         end
      end
      if (sel >= 0) begin
         lba = sd_lba_i[sel];
         len = BYTES_PER_BLOCK * (int'(sd_blk_cnt_i[sel]) + 1);
         sd_ack_o[sel] = 1'b1;
         for (int a = 0; a < len; a++) begin
            sd_buff_addr_o = 16'(a);
            sd_buff_dout_o = 8'(lba + lba_t'(a));
            sd_buff_wr_o   = 1'b1;
            @(negedge clk_sys);
         end
         sd_buff_wr_o  = 1'b0;
         sd_ack_o[sel] = 1'b0;
      end
   end

endmodule

/* testbench/selector_tests.txt */
# name op slot arg exp, numbers in hex
# mount: arg image type (hd mfm ds), exp image size; rom: arg extension, exp bytes
# cmd: arg sector, exp 1 when served; pair: slot and exp are the two slots, arg sector
mount_hd1   mount 1 4    1000
mount_dd0   mount 0 0    1000
gate_dd     cmd   0 5    0
gate_hd     cmd   1 5    0
rom_bad     rom   0 3939 10
gate_bad    cmd   0 5    0
rom_hd      rom   0 3831 10
hd_read     cmd   1 5    1
gate_dd2    cmd   0 5    0
rom_dd      rom   0 3431 10
dd_read     cmd   0 7    1
quiet       idle  0 14   0
eject_hd1   mount 1 0    0
hd_keep     cmd   1 9    1
remount_dd1 mount 1 0    800
dd_slot1    cmd   1 9    1
mount_hd2   mount 2 7    800
hd_slot2    cmd   2 3f   1
pair_lo     pair  0 3    1
mount_dd3   mount 3 0    800
pair_hi     pair  1 4    3
hd_late     cmd   2 1    1

/* testbench/tb_drive_selector.sv */
// testbench top for the drive selector; runs the vectors in selector_tests.txt against the DUT
module tb_drive_selector;
   timeunit 1ns;
   timeprecision 100ps;
   import drive_pkg::*;

   localparam int DRIVES    = 4;
   localparam int ROM_BYTES = 16;

   logic clk_sys = 1'b0;
   logic rst_n_i;
   logic [DRIVES-1:0] img_mounted_i, sd_ack, sd_rd_o, led_o;
   logic [31:0] img_size_i, rom_file_ext_i;
   img_type_t img_type_i;
   logic rom_wr_i, par_stb_i, sd_buff_wr, iec_data_o, par_stb_o;
   logic [7:0] par_data_i, sd_buff_dout, par_data_o;
   logic [15:0] sd_buff_addr;
   lba_t sd_lba_o [DRIVES];
   blk_cnt_t sd_blk_cnt_o [DRIVES];

   string t_name [$];
   string t_op [$];
   logic [31:0] t_slot [$], t_arg [$], t_exp [$];
   logic hd_flag [DRIVES];
   int errors = 0, test_errs, cycles = 0, limit = 0;

   drive_selector #(.DRIVES(DRIVES), .ROM_BYTES(ROM_BYTES)) dut (
      .clk_sys(clk_sys), .rst_n_i(rst_n_i), .img_mounted_i(img_mounted_i),
      .img_size_i(img_size_i), .img_type_i(img_type_i), .rom_file_ext_i(rom_file_ext_i),
      .rom_wr_i(rom_wr_i), .par_data_i(par_data_i), .par_stb_i(par_stb_i),
      .sd_ack_i(sd_ack), .sd_buff_addr_i(sd_buff_addr), .sd_buff_dout_i(sd_buff_dout),
      .sd_buff_wr_i(sd_buff_wr), .led_o(led_o), .iec_data_o(iec_data_o),
      .par_data_o(par_data_o), .par_stb_o(par_stb_o), .sd_rd_o(sd_rd_o),
      .sd_lba_o(sd_lba_o), .sd_blk_cnt_o(sd_blk_cnt_o)
   );

   sd_card_model #(.DRIVES(DRIVES)) u_sd (
      .clk_sys(clk_sys), .rst_n_i(rst_n_i), .sd_rd_i(sd_rd_o), .sd_lba_i(sd_lba_o),
      .sd_blk_cnt_i(sd_blk_cnt_o), .sd_ack_o(sd_ack), .sd_buff_addr_o(sd_buff_addr),
      .sd_buff_dout_o(sd_buff_dout), .sd_buff_wr_o(sd_buff_wr)
   );

   always #10 clk_sys = ~clk_sys;

   always @(posedge clk_sys) begin
      cycles++;
      if (limit > 0 && cycles >= limit) begin
         $display("timeout: run stopped after %0d cycles", cycles);
         $display("Test failed");
         $finish;
      end
   end

   // ------------------------------
   // compare tasks
   // ------------------------------
   task automatic check_byte(string name, logic [7:0] exp, logic [7:0] act);
      if (exp !== act) begin
         $display("error %s expected %h actual %h", name, exp, act);
         test_errs++;
      end
   endtask

   task automatic check_lba(string name, lba_t exp, lba_t act);
      if (exp !== act) begin
         $display("error %s expected %h actual %h", name, exp, act);
         test_errs++;
      end
   endtask

   task automatic check_blk(string name, blk_cnt_t exp, blk_cnt_t act);
      if (exp !== act) begin
         $display("error %s expected %h actual %h", name, exp, act);
         test_errs++;
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (exp !== act) begin
         $display("error %s expected %b actual %b", name, exp, act);
         test_errs++;
      end
   endtask

   task automatic report(string what);
      $display("%s", what);
      test_errs++;
   endtask

   // xor of the model bytes for one sector, hd sectors span two blocks
   function automatic logic [7:0] sector_sum(logic hd, logic [5:0] s);
      lba_t       base;
      int         n;
      logic [7:0] sum;
      base = hd ? lba_t'(s) * 2 : lba_t'(s);
      n    = hd ? 2 * BYTES_PER_BLOCK : BYTES_PER_BLOCK;
      sum  = 8'h00;
      for (int a = 0; a < n; a++) begin
         sum = sum ^ 8'(base + lba_t'(a));
      end
      return sum;
   endfunction

   task automatic send_cmd(int slot, logic [5:0] sec);
      par_data_i = {2'(slot), sec};
      par_stb_i  = 1'b1;
      @(negedge clk_sys);
      par_stb_i  = 1'b0;
   endtask

   task automatic wait_strobe(string name, int max, output logic [7:0] data, output logic seen);
      seen = 1'b0;
      data = 8'h00;
      for (int c = 0; c < max && !seen; c++) begin
         @(negedge clk_sys);
         if (par_stb_o) begin
            seen = 1'b1;
            data = par_data_o;
         end
      end
      if (!seen) report({name, ": no result strobe arrived"});
   endtask

   // single read, or a check that the engine stays quiet
   task automatic run_cmd(string name, int slot, logic [5:0] sec, logic served);
      logic       seen;
      logic [7:0] data;
      send_cmd(slot, sec);
      seen = 1'b0;
      for (int c = 0; c < (served ? 50 : 10) && !seen; c++) begin
         if (sd_rd_o[slot]) seen = 1'b1;
         else @(negedge clk_sys);
      end
      if (!served) begin
         if (seen) report({name, ": read request issued by a gated engine"});
         return;
      end
      if (!seen) begin
         report({name, ": no SD read request"});
         return;
      end
      check_lba(name, hd_flag[slot] ? lba_t'(sec) * 2 : lba_t'(sec), sd_lba_o[slot]);
      check_blk(name, hd_flag[slot] ? blk_cnt_t'(1) : blk_cnt_t'(0), sd_blk_cnt_o[slot]);
      check_bit(name, 1'b0, iec_data_o);
      check_bit(name, 1'b1, led_o[slot]);
      wait_strobe(name, 3000, data, seen);
      if (seen) begin
         check_byte(name, sector_sum(hd_flag[slot], sec), data);
         check_bit(name, 1'b1, iec_data_o);
         check_bit(name, 1'b0, led_o[slot]);
      end
   endtask

   // two slots back to back, plus an ignored repeat to the first
   task automatic run_pair(string name, int lo, int hi, logic [5:0] sec);
      logic       seen;
      logic [7:0] data;
      send_cmd(lo, sec);
      send_cmd(hi, sec);
      send_cmd(lo, sec + 6'd1);  // lo is busy by now
      check_bit(name, 1'b0, iec_data_o);
      check_bit(name, 1'b1, led_o[lo]);
      check_bit(name, 1'b1, led_o[hi]);
      wait_strobe(name, 3000, data, seen);
      if (seen) check_byte(name, sector_sum(hd_flag[lo], sec), data);
      wait_strobe(name, 3000, data, seen);
      if (seen) check_byte(name, sector_sum(hd_flag[hi], sec), data);
      for (int c = 0; c < 40; c++) begin
         @(negedge clk_sys);
         if (par_stb_o) report({name, ": repeated command to a busy slot was served"});
      end
      check_bit(name, 1'b1, iec_data_o);
      check_bit(name, 1'b0, led_o[lo] | led_o[hi]);
   endtask

   initial begin : main
      int    fd;
      string line, name, op;
      logic [31:0] slot, arg, exp;
      void'($urandom(32'h20de));
      rst_n_i = 1'b0;
      img_mounted_i = '0;
      img_size_i = '0;
      img_type_i = '0;
      rom_file_ext_i = '0;
      rom_wr_i = 1'b0;
      par_data_i = '0;
      par_stb_i = 1'b0;
      for (int i = 0; i < DRIVES; i++) hd_flag[i] = 1'b0;

      fd = $fopen("testbench/selector_tests.txt", "r");
      if (fd == 0) begin
         $display("cannot open the test vector file");
         $display("Test failed");
         $finish;
      end else begin
         while ($fgets(line, fd)) begin
            if (line.len() < 2 || line[0] == "#") continue;
            if ($sscanf(line, "%s %s %h %h %h", name, op, slot, arg, exp) == 5) begin
               t_name.push_back(name);
               t_op.push_back(op);
               t_slot.push_back(slot);
               t_arg.push_back(arg);
               t_exp.push_back(exp);
            end
         end
         $fclose(fd);
         limit = t_name.size() * 3000;

         repeat (5) @(negedge clk_sys);
         rst_n_i = 1'b1;
         @(negedge clk_sys);

         foreach (t_name[t]) begin
            test_errs = 0;
            case (t_op[t])
               "mount": begin
                  img_mounted_i[t_slot[t]] = 1'b1;
                  img_type_i = img_type_t'(t_arg[t][2:0]);
                  img_size_i = t_exp[t];
                  @(negedge clk_sys);
                  img_mounted_i = '0;
                  if (t_exp[t] != 0) hd_flag[t_slot[t]] = t_arg[t][2];  // size 0 keeps type
                  @(negedge clk_sys);
               end
               "rom": begin
                  rom_file_ext_i = {16'h0, t_arg[t][15:0]};
                  for (int b = 0; b < int'(t_exp[t]); b++) begin
                     rom_wr_i = 1'b1;
                     @(negedge clk_sys);
                  end
                  rom_wr_i = 1'b0;
                  @(negedge clk_sys);
               end
               "cmd":  run_cmd(t_name[t], t_slot[t], t_arg[t][5:0], t_exp[t][0]);
               "pair": run_pair(t_name[t], t_slot[t], t_exp[t], t_arg[t][5:0]);
               "idle": repeat (t_arg[t]) @(negedge clk_sys);
               default: report({t_name[t], ": unknown operation ", t_op[t]});
            endcase
            repeat ($urandom_range(1, 4)) @(negedge clk_sys);
            if (test_errs == 0) $display("%-12s ok", t_name[t]);
            else $display("%-12s %0d mismatches", t_name[t], test_errs);
            errors += test_errs;
         end

         $display("tests run %0d, mismatches %0d", t_name.size(), errors);
         if (errors == 0) begin
            $display("Test passed");
         end else begin
            $display("Test failed");
         end
         $finish;
      end
   end

endmodule
